/* Bender.yml */
package:
  name: frontend

sources:
  - include_dirs:
      - source
    files:
      - source/isa_pkg.sv
      - source/pipe_pkg.sv
      - source/fetch_pc_stage.sv
      - source/fetch_regs.sv
      - source/decode_stage.sv
      - source/frontend_top.sv
  - target: test
    include_dirs:
      - source
      - tests
    files:
      - tests/frontend_tb.sv

/* source/core_cfg.svh */
// Core configuration macros: word width, reset pc, nop encoding, buffer depth and credits
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Instruction and address width
`define CFG_WORD_WIDTH 32

// First fetch address after reset
`define CFG_RESET_PC 32'h0000_0100

// ADDI x0, x0, 0
`define CFG_NOP_INSTR 32'h0000_0013

// Response buffer entries in fetch_regs
// Also the number of fetch credits the pc stage starts with
`define CFG_FETCH_BUF_DEPTH 4

// Back-end queue slots seen by decode
`define CFG_UOP_CREDITS 4

`endif

/* source/decode_stage.sv */
// Decode stage: RV32I subset decoder, immediate build, micro-op register and back-end credits
`timescale 1ns/1ns
`include "core_cfg.svh"

module decode_stage (
  input  logic                 d_cache_access,
  input  logic                 arst_n,
  input  pipe_pkg::fetch_pkt_t fetch_pkt,
  input  logic                 uop_credit,
  output logic                 dec_ready,
  output isa_pkg::uop_t        uop
);
  import isa_pkg::*;

  localparam int unsigned W     = `CFG_WORD_WIDTH;
  localparam int unsigned CNT_W = $clog2(`CFG_UOP_CREDITS + 1);
  localparam logic [CNT_W-1:0] CREDITS_MAX = CNT_W'(`CFG_UOP_CREDITS);

  logic [W-1:0]     instr;
  opcode_e          opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [W-1:0]     imm_i;
  logic [W-1:0]     imm_s;
  logic [W-1:0]     imm_b;
  logic [W-1:0]     imm_j;
  alu_fn_e          alu_fn;
  logic             alu_f3_ok;
  uop_t             dec_uop;
  uop_t             hold_q;
  logic [CNT_W-1:0] credit_q;
  logic             send;
  logic             accept;

  assign instr  = fetch_pkt.instr;
  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // Sign-extended immediates per format
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // funct3 to ALU function, shared by OP and OP-IMM
  always_comb
  begin
    alu_f3_ok = 1'b1;
    case (funct3)
      F3_ADD:  alu_fn = FN_ADD;
      F3_SLT:  alu_fn = FN_SLT;
      F3_XOR:  alu_fn = FN_XOR;
      F3_OR:   alu_fn = FN_OR;
      F3_AND:  alu_fn = FN_AND;
      // Shifts and unsigned compare are not supported
      default:
      begin
        alu_fn    = FN_ADD;
        alu_f3_ok = 1'b0;
      end
    endcase
  end

  always_comb
  begin
    dec_uop       = '0;
    dec_uop.valid = 1'b1;
    dec_uop.pc    = fetch_pkt.pc;
    dec_uop.op    = OP_ILLEGAL;
    dec_uop.fn    = FN_ADD;
    // Class first
    if (instr == `CFG_NOP_INSTR)
      dec_uop.op = OP_NOP;
    else
    begin
      case (opcode)
        OPC_OP:
        begin
          if (funct7 == F7_BASE && alu_f3_ok)
          begin
            dec_uop.op = OP_ALU;
            dec_uop.fn = alu_fn;
          end
          else if (funct7 == F7_ALT && funct3 == F3_ADD)
          begin
            dec_uop.op = OP_ALU;
            dec_uop.fn = FN_SUB;
          end
        end
        OPC_OP_IMM:
        begin
          if (alu_f3_ok)
          begin
            dec_uop.op = OP_ALUI;
            dec_uop.fn = alu_fn;
          end
        end
        OPC_LOAD:   if (funct3 == F3_W) dec_uop.op = OP_LOAD;
        OPC_STORE:  if (funct3 == F3_W) dec_uop.op = OP_STORE;
        OPC_BRANCH: if (funct3 == F3_BEQ || funct3 == F3_BNE) dec_uop.op = OP_BRANCH;
        OPC_JAL:    dec_uop.op = OP_JUMP;
        default:    dec_uop.op = OP_ILLEGAL;
      endcase
    end
    // Then operand fields the class actually uses
    case (dec_uop.op)
      OP_ALU:
      begin
        dec_uop.rd  = instr[11:7];
        dec_uop.rs1 = instr[19:15];
        dec_uop.rs2 = instr[24:20];
      end
      OP_ALUI, OP_LOAD:
      begin
        dec_uop.rd  = instr[11:7];
        dec_uop.rs1 = instr[19:15];
        dec_uop.imm = imm_i;
      end
      OP_STORE:
      begin
        dec_uop.rs1 = instr[19:15];
        dec_uop.rs2 = instr[24:20];
        dec_uop.imm = imm_s;
      end
      OP_BRANCH:
      begin
        dec_uop.rs1 = instr[19:15];
        dec_uop.rs2 = instr[24:20];
        dec_uop.imm = imm_b;
      end
      OP_JUMP:
      begin
        dec_uop.rd  = instr[11:7];
        dec_uop.imm = imm_j;
      end
      default:
      begin
        dec_uop.rd = '0;
      end
    endcase
  end

  // Held uop leaves only with a back-end slot
  assign send      = hold_q.valid && (credit_q != '0);
  assign dec_ready = !hold_q.valid || send;
  assign accept    = fetch_pkt.valid && dec_ready;

  always_ff @(posedge d_cache_access or negedge arst_n)
  begin
    if (!arst_n)
      hold_q <= '0;
    else if (accept)
      hold_q <= dec_uop;
    else if (send)
      hold_q.valid <= 1'b0;
  end

  always_ff @(posedge d_cache_access or negedge arst_n)
  begin
    if (!arst_n)
      credit_q <= CREDITS_MAX;
    else if (send && !uop_credit)
      credit_q <= credit_q - 1'b1;
    else if (!send && uop_credit)
      credit_q <= credit_q + 1'b1;
  end

  // Valid for the send cycle only
  always_comb
  begin
    uop       = hold_q;
    uop.valid = send;
  end

  // Back end returns no more slots than it was given
  assert property (@(posedge d_cache_access) disable iff (!arst_n)
    credit_q <= CREDITS_MAX);

endmodule

/* source/fetch_pc_stage.sv */
// PC stage: fetch address generation, epoch bit, redirect and fetch credit counter
`timescale 1ns/1ns
`include "core_cfg.svh"

module fetch_pc_stage (
  input  logic                d_cache_access,
  input  logic                arst_n,
  input  pipe_pkg::redirect_t redirect,
  input  logic                fetch_credit,
  output pipe_pkg::imem_req_t imem_req,
  output logic                epoch
);
  import pipe_pkg::*;

  localparam int unsigned CNT_W = $clog2(`CFG_FETCH_BUF_DEPTH + 1);
  localparam logic [CNT_W-1:0] CREDITS_MAX = CNT_W'(`CFG_FETCH_BUF_DEPTH);
  localparam logic [`CFG_WORD_WIDTH-1:0] PC_STEP = 'd4;

  logic [`CFG_WORD_WIDTH-1:0] pc_q;
  logic [`CFG_WORD_WIDTH-1:0] base_pc;
  logic                       epoch_q;
  logic                       next_epoch;
  logic [CNT_W-1:0]           credit_q;
  logic                       issue;
  imem_req_t                  req_q;

  // Redirect replaces the sequential pc and starts a new epoch
  always_comb
  begin
    if (redirect.valid)
    begin
      base_pc    = redirect.target;
      next_epoch = ~epoch_q;
    end
    else
    begin
      base_pc    = pc_q;
      next_epoch = epoch_q;
    end
  end

  // Issue only while a buffer slot is reserved for the answer
  assign issue = (credit_q != '0);

  always_ff @(posedge d_cache_access or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pc_q    <= `CFG_RESET_PC;
      epoch_q <= 1'b0;
      req_q   <= '0;
    end
    else
    begin
      epoch_q     <= next_epoch;
      req_q.valid <= issue;
      req_q.addr  <= base_pc;
      req_q.epoch <= next_epoch;
      // Without a credit the pc waits, target included
      if (issue)
        pc_q <= base_pc + PC_STEP;
      else
        pc_q <= base_pc;
    end
  end

  // One spent per request, one back per buffer pop
  always_ff @(posedge d_cache_access or negedge arst_n)
  begin
    if (!arst_n)
      credit_q <= CREDITS_MAX;
    else if (issue && !fetch_credit)
      credit_q <= credit_q - 1'b1;
    else if (!issue && fetch_credit)
      credit_q <= credit_q + 1'b1;
  end

  assign imem_req = req_q;
  assign epoch    = epoch_q;

  // fetch_regs never returns more credits than requests went out
  assert property (@(posedge d_cache_access) disable iff (!arst_n)
    fetch_credit |-> credit_q != CREDITS_MAX);

endmodule

/* source/fetch_regs.sv */
// Fetch register stage: response buffer, output register, stale-to-NOP conversion and lock
`timescale 1ns/1ns
`include "core_cfg.svh"

module fetch_regs (
  input  logic                 d_cache_access,
  input  logic                 arst_n,
  input  pipe_pkg::imem_rsp_t  imem_rsp,
  input  logic                 epoch,
  input  logic                 lock_set,
  input  logic                 lock_clear,
  input  logic                 dec_ready,
  output pipe_pkg::fetch_pkt_t fetch_pkt,
  output logic                 fetch_credit
);
  import pipe_pkg::*;

  localparam int unsigned DEPTH = `CFG_FETCH_BUF_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

  // Response buffer storage
  logic [`CFG_WORD_WIDTH-1:0] buf_data [DEPTH];
  logic [`CFG_WORD_WIDTH-1:0] buf_addr [DEPTH];
  logic                       buf_epoch [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             lock_q;
  fetch_pkt_t       out_q;
  logic             push;
  logic             pop;
  logic             fire;
  logic             head_stale;

  assign push = imem_rsp.valid;
  // Decode takes the current packet
  assign fire = fetch_pkt.valid && dec_ready;
  // Head moves to the output register when it is free or being freed
  assign pop  = !lock_q && (count_q != '0) && (!out_q.valid || fire);
  // Head fetched before the last redirect
  assign head_stale = (buf_epoch[rd_ptr_q] != epoch);

  always_ff @(posedge d_cache_access)
  begin
    if (push)
    begin
      buf_data[wr_ptr_q]  <= imem_rsp.data;
      buf_addr[wr_ptr_q]  <= imem_rsp.addr;
      buf_epoch[wr_ptr_q] <= imem_rsp.epoch;
    end
  end

  always_ff @(posedge d_cache_access or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Lock from the data-cache side, clear has priority
  always_ff @(posedge d_cache_access or negedge arst_n)
  begin
    if (!arst_n)
      lock_q <= 1'b0;
    else if (lock_clear)
      lock_q <= 1'b0;
    else if (lock_set)
      lock_q <= 1'b1;
  end

  // Output register, wrong-path entries keep their pc but become bubbles
  always_ff @(posedge d_cache_access or negedge arst_n)
  begin
    if (!arst_n)
      out_q <= '0;
    else if (pop)
    begin
      out_q.valid <= 1'b1;
      out_q.instr <= head_stale ? `CFG_NOP_INSTR : buf_data[rd_ptr_q];
      out_q.pc    <= buf_addr[rd_ptr_q];
    end
    else if (fire)
      out_q.valid <= 1'b0;
  end

  // Held packet is hidden while locked
  always_comb
  begin
    fetch_pkt       = out_q;
    fetch_pkt.valid = out_q.valid && !lock_q;
  end

  // Each pop frees a slot for the pc stage
  assign fetch_credit = pop;

  // Credit loop with the pc stage keeps the buffer from overflowing
  assert property (@(posedge d_cache_access) disable iff (!arst_n)
    imem_rsp.valid |-> count_q < CNT_W'(DEPTH));

  // Locked output register neither loads nor drains
  assert property (@(posedge d_cache_access) disable iff (!arst_n)
    lock_q |=> $stable(out_q));

endmodule

/* source/frontend_top.sv */
// Front end top: pc stage, fetch register stage and decode stage
`timescale 1ns/1ns

module frontend_top (
  input  logic                d_cache_access,
  input  logic                arst_n,
  // Instruction memory port
  output pipe_pkg::imem_req_t imem_req,
  input  pipe_pkg::imem_rsp_t imem_rsp,
  // Taken branch target
  input  pipe_pkg::redirect_t redirect,
  // Data-cache lock pulses
  input  logic                lock_set,
  input  logic                lock_clear,
  // Back-end side
  output isa_pkg::uop_t       uop,
  input  logic                uop_credit
);
  import pipe_pkg::*;

  fetch_pkt_t fetch_pkt;
  logic       epoch;
  logic       fetch_credit;
  logic       dec_ready;

  // Address generation, spends fetch credits
  fetch_pc_stage u_fetch_pc_stage (
    .d_cache_access (d_cache_access),
    .arst_n         (arst_n),
    .redirect       (redirect),
    .fetch_credit   (fetch_credit),
    .imem_req       (imem_req),
    .epoch          (epoch)
  );

  // Buffers answers, returns fetch credits
  fetch_regs u_fetch_regs (
    .d_cache_access (d_cache_access),
    .arst_n         (arst_n),
    .imem_rsp       (imem_rsp),
    .epoch          (epoch),
    .lock_set       (lock_set),
    .lock_clear     (lock_clear),
    .dec_ready      (dec_ready),
    .fetch_pkt      (fetch_pkt),
    .fetch_credit   (fetch_credit)
  );

  // Valid/ready from fetch_regs, credits toward the back end
  decode_stage u_decode_stage (
    .d_cache_access (d_cache_access),
    .arst_n         (arst_n),
    .fetch_pkt      (fetch_pkt),
    .uop_credit     (uop_credit),
    .dec_ready      (dec_ready),
    .uop            (uop)
  );

endmodule

/* source/isa_pkg.sv */
// ISA package: opcode and funct field enums, micro-op opcode and ALU enums, micro-op struct
`include "core_cfg.svh"

package isa_pkg;

  // Major opcodes of the RV32I base formats
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  // funct7 for register-register ALU ops
  typedef enum logic [6:0] {
    F7_BASE = 7'b0000000,
    F7_ALT  = 7'b0100000
  } funct7_e;

  // funct3 of the supported ALU ops, shared by OP and OP-IMM
  typedef enum logic [2:0] {
    F3_ADD = 3'b000,
    F3_SLT = 3'b010,
    F3_XOR = 3'b100,
    F3_OR  = 3'b110,
    F3_AND = 3'b111
  } alu_f3_e;

  // Load and store access size
  typedef enum logic [2:0] {
    F3_B = 3'b000,
    F3_H = 3'b001,
    F3_W = 3'b010
  } mem_f3_e;

  // Branch conditions
  typedef enum logic [2:0] {
    F3_BEQ = 3'b000,
    F3_BNE = 3'b001
  } br_f3_e;

  // Micro-op classes handed to the back end
  typedef enum logic [2:0] {
    OP_NOP, OP_ALU, OP_ALUI, OP_LOAD, OP_STORE, OP_BRANCH, OP_JUMP, OP_ILLEGAL
  } uop_op_e;

  // ALU function, FN_ADD also for non-ALU classes
  typedef enum logic [2:0] {
    FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_SLT
  } alu_fn_e;

  // Decoded micro-op
  typedef struct packed {
    logic                       valid;
    uop_op_e                    op;
    alu_fn_e                    fn;
    logic [4:0]                 rd;
    logic [4:0]                 rs1;
    logic [4:0]                 rs2;
    logic [`CFG_WORD_WIDTH-1:0] imm;
    logic [`CFG_WORD_WIDTH-1:0] pc;
  } uop_t;

endpackage

/* source/pipe_pkg.sv */
// Pipeline package: instruction memory request and response, fetch packet and redirect structs
`include "core_cfg.svh"

package pipe_pkg;

  // Fetch request toward instruction memory
  typedef struct packed {
    logic                       valid;
    logic [`CFG_WORD_WIDTH-1:0] addr;
    // Epoch at issue time, echoed back by memory
    logic                       epoch;
  } imem_req_t;

  // In-order memory answer
  // addr comes back with the data and becomes the packet pc
  typedef struct packed {
    logic                       valid;
    logic [`CFG_WORD_WIDTH-1:0] data;
    logic [`CFG_WORD_WIDTH-1:0] addr;
    logic                       epoch;
  } imem_rsp_t;

  // Fetch register to decode, one entry
  typedef struct packed {
    logic                       valid;
    logic [`CFG_WORD_WIDTH-1:0] instr;
    logic [`CFG_WORD_WIDTH-1:0] pc;
  } fetch_pkt_t;

  // Taken branch from the back end
  typedef struct packed {
    logic                       valid;
    logic [`CFG_WORD_WIDTH-1:0] target;
  } redirect_t;

endpackage

/* tests/frontend_tests.svh */
// Directed test tasks: sequential fetch, decode coverage, credits, redirect and lock
`ifndef FRONTEND_TESTS_SVH
`define FRONTEND_TESTS_SVH

// Wait for n more non-NOP uops, bounded
task automatic wait_uops(int unsigned n, int unsigned limit);
  int unsigned target;
  int unsigned cycles;
  target = uop_count + n;
  cycles = 0;
  while (uop_count < target && cycles < limit)
  begin
    @(posedge d_cache_access);
    #1;
    cycles++;
  end
  assert (uop_count >= target)
  else
  begin
    errors++;
    $display("Timeout while waiting for %0d uops", n);
  end
endtask

task automatic test_sequential();
  wait_uops(20, 400);
  check_field("imem_req.addr", first_addr, `CFG_RESET_PC);
endtask

// Every class and every ALU function must have shown up
task automatic test_decode();
  wait_uops(16, 400);
  for (int k = 1; k < 8; k++)
    assert (seen_op[k])
    else
    begin
      errors++;
      $display("No uop seen for op class %0d", k);
    end
  for (int k = 0; k < 6; k++)
    assert (seen_fn[k])
    else
    begin
      errors++;
      $display("No ALU uop seen for fn %0d", k);
    end
endtask

// Withheld credits cap the uop stream
task automatic test_uop_credits();
  int unsigned base;
  @(posedge d_cache_access);
  hold_credits = 1'b1;
  #1;
  base = uop_count;
  repeat (60) @(posedge d_cache_access);
  hold_credits = 1'b0;
  #1;
  assert (uop_count - base <= `CFG_UOP_CREDITS)
  else
  begin
    errors++;
    $display("Decode sent uops without back-end credits");
  end
  wait_uops(12, 400);
endtask

// Long stall, memory requests stay bounded by the buffer depth
task automatic test_fetch_credits();
  @(posedge d_cache_access);
  hold_credits = 1'b1;
  #1;
  max_out = 0;
  repeat (120) @(posedge d_cache_access);
  hold_credits = 1'b0;
  #1;
  assert (max_out <= `CFG_FETCH_BUF_DEPTH)
  else
  begin
    errors++;
    $display("Too many memory requests in flight during the stall");
  end
  wait_uops(12, 400);
endtask

task automatic test_redirect();
  @(posedge d_cache_access);
  #1;
  redirect      = '{valid: 1'b1, target: 32'h0000_8000};
  redir_target  = 32'h0000_8000;
  redir_pending = 1'b1;
  // Output register, decode register and the uop on the wire
  old_allow     = 3;
  @(posedge d_cache_access);
  #1 redirect = '0;
  wait_uops(10, 400);
  assert (!redir_pending)
  else
  begin
    errors++;
    $display("No uop from the redirect target arrived");
  end
endtask

task automatic test_lock();
  int unsigned base;
  @(posedge d_cache_access);
  #1;
  base     = uop_count;
  lock_set = 1'b1;
  @(posedge d_cache_access);
  #1 lock_set = 1'b0;
  repeat (30) @(posedge d_cache_access);
  #1;
  assert (uop_count - base <= 2)
  else
  begin
    errors++;
    $display("Uops kept flowing while the fetch register was locked");
  end
  lock_clear = 1'b1;
  @(posedge d_cache_access);
  #1 lock_clear = 1'b0;
  wait_uops(10, 400);
endtask

`endif

/* tests/frontend_tb.sv */
// Front end testbench: clock, reset, DUT, LCG, memory model, credit return and uop monitor
`timescale 1ns/1ns
`include "core_cfg.svh"

module frontend_tb;
  import isa_pkg::*;
  import pipe_pkg::*;

  localparam logic [31:0] NOP = `CFG_NOP_INSTR;

  logic        d_cache_access;
  logic        arst_n;
  imem_req_t   imem_req;
  imem_rsp_t   imem_rsp;
  redirect_t   redirect;
  logic        lock_set;
  logic        lock_clear;
  uop_t        uop;
  logic        uop_credit;

  int unsigned errors;
  int unsigned uop_count;
  int unsigned cyc;
  int unsigned req_cnt;
  int unsigned rsp_cnt;
  int unsigned max_out;
  int unsigned owed;
  int unsigned seed;
  int unsigned lat;
  int unsigned rdy;
  int unsigned last_rdy;
  int          old_allow;
  bit          hold_credits;
  bit          have_req;
  bit          redir_pending;
  bit          seen_op [8];
  bit          seen_fn [8];
  logic [31:0] exp_pc;
  logic [31:0] redir_target;
  logic [31:0] first_addr;
  logic [31:0] last_addr;
  // Memory requests waiting for their answer
  logic [31:0] q_addr [$];
  logic        q_epoch [$];
  int unsigned q_rdy [$];

  frontend_top u_frontend_top (
    .d_cache_access (d_cache_access),
    .arst_n         (arst_n),
    .imem_req       (imem_req),
    .imem_rsp       (imem_rsp),
    .redirect       (redirect),
    .lock_set       (lock_set),
    .lock_clear     (lock_clear),
    .uop            (uop),
    .uop_credit     (uop_credit)
  );

  initial
  begin
    d_cache_access = 1'b0;
    forever #2 d_cache_access = ~d_cache_access;
  end

  function automatic int unsigned lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed >> 16;
  endfunction

  // Instruction encoders per RV32I format
  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // Program repeats every 16 words, holds no NOP
  function automatic logic [31:0] prog_instr(logic [31:0] addr);
    case (addr[5:2])
      4'd0:    return enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3);
      4'd1:    return enc_r(7'h20, 5'd7, 5'd6, 3'd0, 5'd5);
      4'd2:    return enc_r(7'h00, 5'd10, 5'd9, 3'd7, 5'd8);
      4'd3:    return enc_r(7'h00, 5'd1, 5'd2, 3'd6, 5'd4);
      4'd4:    return enc_r(7'h00, 5'd12, 5'd11, 3'd4, 5'd13);
      4'd5:    return enc_r(7'h00, 5'd15, 5'd14, 3'd2, 5'd16);
      4'd6:    return enc_i(-12'sd5, 5'd2, 3'd0, 5'd1, 7'b0010011);
      4'd7:    return enc_i(12'h123, 5'd5, 3'd4, 5'd4, 7'b0010011);
      4'd8:    return enc_i(12'h800, 5'd20, 3'd2, 5'd21, 7'b0010011);
      4'd9:    return enc_i(-12'sd16, 5'd7, 3'd2, 5'd6, 7'b0000011);
      4'd10:   return enc_s(12'd20, 5'd8, 5'd9);
      4'd11:   return enc_b(-13'sd8, 5'd2, 5'd1, 3'd0);
      4'd12:   return enc_b(13'h040, 5'd4, 5'd3, 3'd1);
      4'd13:   return enc_j(-21'sd2048, 5'd1);
      // Opcode zero is not a valid instruction
      4'd14:   return 32'h0000_0000;
      default: return enc_i(12'hfff, 5'd11, 3'd6, 5'd10, 7'b0010011);
    endcase
  endfunction

  // Immediate each program word was encoded with, zero where the format has none
  function automatic logic [31:0] prog_imm(logic [31:0] addr);
    case (addr[5:2])
      4'd6:    return -32'sd5;
      4'd7:    return 32'h0000_0123;
      4'd8:    return -32'sd2048;
      4'd9:    return -32'sd16;
      4'd10:   return 32'd20;
      4'd11:   return -32'sd8;
      4'd12:   return 32'h0000_0040;
      4'd13:   return -32'sd2048;
      4'd15:   return -32'sd1;
      default: return 32'h0000_0000;
    endcase
  endfunction

  // Expected class, function and register fields from the decode table
  function automatic uop_t ref_decode(logic [31:0] i, logic [31:0] pc);
    uop_t       u;
    alu_fn_e    fn;
    bit         fn_ok;
    logic [2:0] f3;
    u       = '0;
    u.valid = 1'b1;
    u.pc    = pc;
    u.op    = OP_ILLEGAL;
    u.fn    = FN_ADD;
    f3      = i[14:12];
    fn_ok   = 1'b1;
    case (f3)
      3'd0:    fn = FN_ADD;
      3'd2:    fn = FN_SLT;
      3'd4:    fn = FN_XOR;
      3'd6:    fn = FN_OR;
      3'd7:    fn = FN_AND;
      default:
      begin
        fn    = FN_ADD;
        fn_ok = 1'b0;
      end
    endcase
    if (i == NOP)
      u.op = OP_NOP;
    else if (i[6:0] == 7'h33 && i[31:25] == 7'h00 && fn_ok)
    begin
      u.op = OP_ALU;
      u.fn = fn;
    end
    else if (i[6:0] == 7'h33 && i[31:25] == 7'h20 && f3 == 3'd0)
    begin
      u.op = OP_ALU;
      u.fn = FN_SUB;
    end
    else if (i[6:0] == 7'h13 && fn_ok)
    begin
      u.op = OP_ALUI;
      u.fn = fn;
    end
    else if (i[6:0] == 7'h03 && f3 == 3'd2)
      u.op = OP_LOAD;
    else if (i[6:0] == 7'h23 && f3 == 3'd2)
      u.op = OP_STORE;
    else if (i[6:0] == 7'h63 && f3 < 3'd2)
      u.op = OP_BRANCH;
    else if (i[6:0] == 7'h6f)
      u.op = OP_JUMP;
    // Only the fields each format carries
    if (u.op inside {OP_ALU, OP_ALUI, OP_LOAD, OP_JUMP})
      u.rd = i[11:7];
    if (u.op inside {OP_ALU, OP_ALUI, OP_LOAD, OP_STORE, OP_BRANCH})
      u.rs1 = i[19:15];
    if (u.op inside {OP_ALU, OP_STORE, OP_BRANCH})
      u.rs2 = i[24:20];
    return u;
  endfunction

  task automatic check_field(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp)
    else
    begin
      errors++;
      $display("** Error %s: got %h expected %h", name, got, exp);
    end
  endtask

  // Compare one non-NOP uop against the expected program order
  task automatic check_uop(uop_t u);
    uop_t e;
    if (redir_pending && u.pc == redir_target)
    begin
      exp_pc        = redir_target;
      redir_pending = 1'b0;
    end
    else if (redir_pending)
    begin
      // Only what was already past the buffer may drain
      assert (old_allow > 0)
      else
      begin
        errors++;
        $display("Old-path uop at pc %h seen after redirect", u.pc);
      end
      old_allow--;
    end
    e = ref_decode(prog_instr(exp_pc), exp_pc);
    check_field("uop.pc", u.pc, e.pc);
    check_field("uop.op", 32'(u.op), 32'(e.op));
    check_field("uop.fn", 32'(u.fn), 32'(e.fn));
    check_field("uop.rd", 32'(u.rd), 32'(e.rd));
    check_field("uop.rs1", 32'(u.rs1), 32'(e.rs1));
    check_field("uop.rs2", 32'(u.rs2), 32'(e.rs2));
    check_field("uop.imm", u.imm, prog_imm(exp_pc));
    seen_op[u.op] = 1'b1;
    if (u.op == OP_ALU || u.op == OP_ALUI)
      seen_fn[u.fn] = 1'b1;
    exp_pc = exp_pc + 32'd4;
    uop_count++;
  endtask

  // Uop monitor, bubbles still owe a back-end credit
  always @(posedge d_cache_access)
  begin
    if (arst_n && uop.valid)
    begin
      owed++;
      if (uop.op != OP_NOP)
        check_uop(uop);
    end
  end

  // Memory model and credit return share one random stream
  always @(posedge d_cache_access)
  begin
    cyc++;
    if (arst_n && imem_req.valid)
    begin
      if (!have_req)
        first_addr = imem_req.addr;
      else
        assert (imem_req.addr == last_addr + 32'd4 || imem_req.addr == redir_target)
        else
        begin
          errors++;
          $display("** Error imem_req.addr: got %h expected %h", imem_req.addr,
                   last_addr + 32'd4);
        end
      have_req  = 1'b1;
      last_addr = imem_req.addr;
      lat       = 1 + lcg_next() % 4;
      rdy       = cyc + lat;
      // Answers stay in order
      if (rdy <= last_rdy)
        rdy = last_rdy + 1;
      last_rdy = rdy;
      q_addr.push_back(imem_req.addr);
      q_epoch.push_back(imem_req.epoch);
      q_rdy.push_back(rdy);
      req_cnt++;
    end
    if (req_cnt - rsp_cnt > max_out)
      max_out = req_cnt - rsp_cnt;
    assert (req_cnt - rsp_cnt <= `CFG_FETCH_BUF_DEPTH)
    else
    begin
      errors++;
      $display("More memory requests outstanding than the fetch buffer holds");
    end
    #1;
    if (q_rdy.size() != 0 && q_rdy[0] <= cyc)
    begin
      imem_rsp.valid = 1'b1;
      imem_rsp.addr  = q_addr.pop_front();
      imem_rsp.data  = prog_instr(imem_rsp.addr);
      imem_rsp.epoch = q_epoch.pop_front();
      void'(q_rdy.pop_front());
      rsp_cnt++;
    end
    else
      imem_rsp = '0;
    if (!hold_credits && owed > 0 && lcg_next() % 4 != 0)
    begin
      uop_credit = 1'b1;
      owed--;
    end
    else
      uop_credit = 1'b0;
  end

  `include "frontend_tests.svh"

  initial
  begin
    arst_n        = 1'b0;
    imem_rsp      = '0;
    redirect      = '0;
    lock_set      = 1'b0;
    lock_clear    = 1'b0;
    uop_credit    = 1'b0;
    seed          = 27;
    exp_pc        = `CFG_RESET_PC;
    redir_target  = '0;
    redir_pending = 1'b0;
    hold_credits  = 1'b0;
    repeat (3) @(posedge d_cache_access);
    #1 arst_n = 1'b1;
    test_sequential();
    test_decode();
    test_uop_credits();
    test_fetch_credits();
    test_redirect();
    test_lock();
    $display("Checked %0d uops, %0d errors", uop_count, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+source
+incdir+tests
source/isa_pkg.sv
source/pipe_pkg.sv
source/fetch_pc_stage.sv
source/fetch_regs.sv
source/decode_stage.sv
source/frontend_top.sv
tests/frontend_tb.sv
